// File: Bender.yml
package:
  name: debug_unit

sources:
  - include_dirs:
      - source
    files:
      - source/du_cpu_pkg.sv
      - source/du_cmd_pkg.sv
      - source/du_cmd_decoder.sv
      - source/du_program_loader.sv
      - source/du_word_sender.sv
      - source/debug_unit.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/debug_unit_properties.sv
      - sim/debug_unit_tb.sv

// File: compile.f
+incdir+source
source/du_cpu_pkg.sv
source/du_cmd_pkg.sv
source/du_cmd_decoder.sv
source/du_program_loader.sv
source/du_word_sender.sv
source/debug_unit.sv
sim/debug_unit_properties.sv
sim/debug_unit_tb.sv

// File: sim/debug_unit_properties.sv
module debug_unit_properties (
    input logic i_du_clk,
    input logic i_du_reset,
    input logic o_tx_valid,
    input logic o_inst_write_en,
    input logic o_clk_en,
    input logic o_step_mode,
    input logic o_cpu_reset
);

    int error_count = 0;

    // Reset pulse to the CPU lasts one cycle
    cpu_reset_single: assert property (@(posedge i_du_clk) disable iff (i_du_reset)
        o_cpu_reset |=> !o_cpu_reset)
    else begin
        $error("CPU reset stayed high for two cycles");
        error_count++;
    end

    tx_write_exclusive: assert property (@(posedge i_du_clk) disable iff (i_du_reset)
        !(o_tx_valid && o_inst_write_en))
    else begin
        $error("Transmit and instruction write were active together");
        error_count++;
    end

    step_needs_clk: assert property (@(posedge i_du_clk) disable iff (i_du_reset)
        o_step_mode |-> o_clk_en)
    else begin
        $error("Step mode without CPU clock enable");
        error_count++;
    end

    controls_low_after_reset: assert property (@(posedge i_du_clk)
        i_du_reset |=> !(o_clk_en || o_step_mode || o_cpu_reset || o_inst_write_en || o_tx_valid))
    else begin
        $error("A control output was high in the cycle after reset");
        error_count++;
    end

endmodule

bind debug_unit debug_unit_properties u_props (.*);

// File: sim/debug_unit_tb.sv
`include "du_macros.svh"

module debug_unit_tb
    import du_cmd_pkg::*;
    import du_cpu_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 10;

    logic         i_du_clk;
    logic         i_du_reset;
    logic         i_rx_valid;
    du_byte_t     i_rx_data;
    logic         i_halt;
    du_word_t     i_reg_data;
    du_word_t     i_mem_data;
    logic         o_tx_valid;
    du_byte_t     o_tx_data;
    du_word_t     o_inst_data;
    du_mem_addr_t o_inst_addr;
    logic         o_inst_write_en;
    du_reg_addr_t o_reg_addr;
    du_mem_addr_t o_mem_addr;
    logic         o_clk_en;
    logic         o_step_mode;
    logic         o_cpu_reset;

    du_word_t     reg_table [32];
    du_word_t     mem_table [256];
    logic [31:0]  rng_state = 32'h72a0_fa62;

    string        test_name [$];
    du_byte_t     test_cmd [$];
    int           test_arg [$];            // Word count, address or run length
    du_word_t     test_exp [$];
    int           words_to_load = 0;
    logic         table_ready = 1'b0;

    du_word_t     wr_data_log [$];
    du_mem_addr_t wr_addr_log [$];
    du_byte_t     tx_log [$];
    int           wr_count;
    int           tx_count;
    int           clk_en_count;
    int           step_count;
    int           cpu_reset_count;

    debug_unit UUT (.*);

    initial begin
        i_du_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) i_du_clk = ~i_du_clk;
        end
    end

    // CPU side models with register 0 as the MIPS zero register
    always_comb begin
        case (o_reg_addr)
            '0:      i_reg_data = '0;
            default: i_reg_data = reg_table[o_reg_addr];
        endcase
        i_mem_data = mem_table[o_mem_addr];
    end

    // Mid-cycle monitors
    always @(negedge i_du_clk) begin
        if (o_inst_write_en === 1'b1) begin
            wr_data_log.push_back(o_inst_data);
            wr_addr_log.push_back(o_inst_addr);
            wr_count++;
        end
        if (o_tx_valid === 1'b1) begin
            tx_log.push_back(o_tx_data);
            tx_count++;
        end
        if (o_clk_en === 1'b1) begin
            clk_en_count++;
        end
        if (o_clk_en === 1'b1 && o_step_mode === 1'b1) begin
            step_count++;
        end
        if (o_cpu_reset === 1'b1) begin
            cpu_reset_count++;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s %s: expected %h, actual %h", test, what, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "Check failed in %s", test);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge i_du_clk);
        #(DRIVE_DELAY);
    endtask

    task automatic send_byte(input du_byte_t b);
        i_rx_valid = 1'b1;
        i_rx_data  = b;
        idle_cycles(1);
        i_rx_valid = 1'b0;
    endtask

    task automatic send_word(input du_word_t w);
        du_word_t rest;
        rest = w;
        repeat (`DU_BYTES_PER_WORD) begin
            send_byte(rest[`DU_WORD_W-1 -: `DU_BYTE_W]); // MSB first
            rest = rest << `DU_BYTE_W;
        end
    endtask

    task automatic clear_logs();
        wr_data_log.delete();
        wr_addr_log.delete();
        tx_log.delete();
        wr_count        = 0;
        tx_count        = 0;
        clk_en_count    = 0;
        step_count      = 0;
        cpu_reset_count = 0;
    endtask

    task automatic add_test(input string name, input du_byte_t cmd, input int arg,
                            input du_word_t expected);
        test_name.push_back(name);
        test_cmd.push_back(cmd);
        test_arg.push_back(arg);
        test_exp.push_back(expected);
        if (cmd == CMD_LOAD) begin
            words_to_load += arg + 1;
        end
    endtask

    task automatic build_tables();
        int run_len;
        int rand_reg;
        int rand_mem;
        for (int i = 0; i < 32; i++) begin
            reg_table[i] = next_random();
        end
        reg_table[0] = '0;
        for (int i = 0; i < 256; i++) begin
            mem_table[i] = next_random();
        end
        run_len  = 1 + int'(next_random() % 20);
        rand_reg = int'(next_random() % 32);
        rand_mem = int'(next_random() % 256);
        add_test("load_five_words", CMD_LOAD, 5, 6);
        add_test("read_reg_3", CMD_READ_REG, 3, reg_table[3]);
        add_test("read_reg_31", CMD_READ_REG, 31, reg_table[31]);
        add_test("read_reg_zero", CMD_READ_REG, 0, reg_table[0]);
        add_test("read_reg_random", CMD_READ_REG, rand_reg, reg_table[rand_reg]);
        add_test("read_mem_8", CMD_READ_MEM, 8, mem_table[8]);
        add_test("read_mem_255", CMD_READ_MEM, 255, mem_table[255]);
        add_test("run_until_halt", CMD_RUN, run_len, run_len);
        add_test("single_step", CMD_STEP, 0, 1);
        add_test("cpu_reset_pulse", CMD_RESET, 0, 1);
        add_test("unknown_cmd_03", 8'h03, 0, 0);
        add_test("read_mem_after_unknown", CMD_READ_MEM, rand_mem, mem_table[rand_mem]);
        add_test("reload_two_words", CMD_LOAD, 2, 3);
    endtask

    task automatic run_load(input int t);
        du_word_t sent [$];
        du_word_t word;
        send_byte(test_cmd[t]);
        for (int i = 0; i < test_arg[t]; i++) begin
            word = next_random();
            if (word == `DU_HALT_WORD) begin
                word = ~word;
            end
            sent.push_back(word);
        end
        sent.push_back(`DU_HALT_WORD);
        for (int i = 0; i < sent.size(); i++) begin
            send_word(sent[i]);
        end
        wait (wr_count >= test_exp[t]);
        idle_cycles(1);
        send_word(32'hAA55_0011);             // No lane holds a command byte
        idle_cycles(3);
        check_value(test_name[t], "write count", test_exp[t], wr_count);
        for (int i = 0; i < sent.size(); i++) begin
            check_value(test_name[t], "write address", i * `DU_ADDR_STEP, wr_addr_log[i]);
            check_value(test_name[t], "write data", sent[i], wr_data_log[i]);
        end
    endtask

    task automatic run_read(input int t);
        du_word_t actual;
        send_byte(test_cmd[t]);
        send_byte(du_byte_t'(test_arg[t]));
        wait (tx_count >= `DU_BYTES_PER_WORD);
        idle_cycles(3);
        check_value(test_name[t], "tx byte count", `DU_BYTES_PER_WORD, tx_count);
        actual = {tx_log[0], tx_log[1], tx_log[2], tx_log[3]};
        check_value(test_name[t], "read word", test_exp[t], actual);
        if (test_cmd[t] == CMD_READ_REG) begin
            check_value(test_name[t], "register address", test_arg[t], o_reg_addr);
        end else begin
            check_value(test_name[t], "memory address", test_arg[t], o_mem_addr);
        end
    endtask

    task automatic run_free(input int t);
        send_byte(test_cmd[t]);
        idle_cycles(test_arg[t] - 1);
        i_halt = 1'b1;                        // Seen at the edge after the last run cycle
        wait (o_clk_en == 1'b0);
        idle_cycles(1);
        i_halt = 1'b0;
        idle_cycles(2);
        check_value(test_name[t], "clk_en cycles", test_exp[t], clk_en_count);
        check_value(test_name[t], "step cycles", 0, step_count);
        check_value(test_name[t], "clk_en after halt", 0, o_clk_en);
    endtask

    task automatic run_pulse(input int t);
        logic is_step;
        is_step = (test_cmd[t] == CMD_STEP);
        send_byte(test_cmd[t]);
        wait (clk_en_count + cpu_reset_count >= 1);
        idle_cycles(3);
        check_value(test_name[t], "pulse cycles", test_exp[t],
                    is_step ? step_count : cpu_reset_count);
        check_value(test_name[t], "clk_en cycles", is_step ? test_exp[t] : 0, clk_en_count);
        check_value(test_name[t], "other pulse", 0, is_step ? cpu_reset_count : step_count);
    endtask

    task automatic run_unknown(input int t);
        send_byte(test_cmd[t]);
        idle_cycles(5);
        check_value(test_name[t], "activity cycles", test_exp[t],
                    wr_count + tx_count + clk_en_count + cpu_reset_count);
    endtask

    initial begin : watchdog
        int limit;
        wait (table_ready);
        limit = RESET_CYCLES + 40 * test_name.size() + 8 * words_to_load;
        repeat (limit) @(posedge i_du_clk);
        $display("Watchdog expired after %0d cycles, a test never completed", limit);
        $display("Simulation finished: FAIL");
        $fatal(1, "Watchdog timeout");
    end

    initial begin : main
        i_du_reset = 1'b1;
        i_rx_valid = 1'b0;
        i_rx_data  = '0;
        i_halt     = 1'b0;
        clear_logs();
        build_tables();
        table_ready = 1'b1;
        idle_cycles(RESET_CYCLES);
        i_du_reset = 1'b0;

        idle_cycles(5);
        check_value("reset_idle", "activity cycles", 0,
                    wr_count + tx_count + clk_en_count + cpu_reset_count);
        check_value("reset_idle", "addresses", 0, {o_inst_addr, o_reg_addr, o_mem_addr});

        for (int t = 0; t < test_name.size(); t++) begin
            clear_logs();
            case (test_cmd[t])
                CMD_LOAD:               run_load(t);
                CMD_READ_REG, CMD_READ_MEM: run_read(t);
                CMD_RUN:                run_free(t);
                CMD_STEP, CMD_RESET:    run_pulse(t);
                default:                run_unknown(t);
            endcase
        end

        if (UUT.u_props.error_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Bound property checks failed %0d times", UUT.u_props.error_count);
            $display("Simulation finished: FAIL");
            $fatal(1, "Property failures");
        end
    end

endmodule

// File: source/debug_unit.sv
`include "du_macros.svh"

module debug_unit
    import du_cpu_pkg::*;
(
    input  logic         i_du_clk,
    input  logic         i_du_reset,
    input  logic         i_rx_valid,
    input  du_byte_t     i_rx_data,
    input  logic         i_halt,
    input  du_word_t     i_reg_data,
    input  du_word_t     i_mem_data,
    output logic         o_tx_valid,
    output du_byte_t     o_tx_data,
    output du_word_t     o_inst_data,
    output du_mem_addr_t o_inst_addr,
    output logic         o_inst_write_en,
    output du_reg_addr_t o_reg_addr,
    output du_mem_addr_t o_mem_addr,
    output logic         o_clk_en,
    output logic         o_step_mode,
    output logic         o_cpu_reset
);

    logic load_start;
    logic load_byte_valid;
    logic load_done;
    logic send_reg;
    logic send_mem;
    logic send_done;

    du_cmd_decoder u_decoder (
        .i_du_clk          (i_du_clk),
        .i_du_reset        (i_du_reset),
        .i_rx_valid        (i_rx_valid),
        .i_rx_data         (i_rx_data),
        .i_halt            (i_halt),
        .i_load_done       (load_done),
        .i_send_done       (send_done),
        .o_load_start      (load_start),
        .o_load_byte_valid (load_byte_valid),
        .o_send_reg        (send_reg),
        .o_send_mem        (send_mem),
        .o_reg_addr        (o_reg_addr),
        .o_mem_addr        (o_mem_addr),
        .o_clk_en          (o_clk_en),
        .o_step_mode       (o_step_mode),
        .o_cpu_reset       (o_cpu_reset)
    );

    du_program_loader u_loader (
        .i_du_clk        (i_du_clk),
        .i_du_reset      (i_du_reset),
        .i_start         (load_start),
        .i_byte_valid    (load_byte_valid),
        .i_byte          (i_rx_data),       // Gating is done by the decoder
        .o_inst_data     (o_inst_data),
        .o_inst_addr     (o_inst_addr),
        .o_inst_write_en (o_inst_write_en),
        .o_done          (load_done)
    );

    du_word_sender u_sender (
        .i_du_clk   (i_du_clk),
        .i_du_reset (i_du_reset),
        .i_send_reg (send_reg),
        .i_send_mem (send_mem),
        .i_reg_word (i_reg_data),
        .i_mem_word (i_mem_data),
        .o_tx_valid (o_tx_valid),
        .o_tx_data  (o_tx_data),
        .o_done     (send_done)
    );

endmodule

// File: source/du_cmd_decoder.sv
`include "du_macros.svh"

module du_cmd_decoder
    import du_cmd_pkg::*;
    import du_cpu_pkg::*;
(
    input  logic         i_du_clk,
    input  logic         i_du_reset,
    input  logic         i_rx_valid,
    input  du_byte_t     i_rx_data,
    input  logic         i_halt,
    input  logic         i_load_done,
    input  logic         i_send_done,
    output logic         o_load_start,
    output logic         o_load_byte_valid,
    output logic         o_send_reg,
    output logic         o_send_mem,
    output du_reg_addr_t o_reg_addr,
    output du_mem_addr_t o_mem_addr,
    output logic         o_clk_en,
    output logic         o_step_mode,
    output logic         o_cpu_reset
);

    du_state_e state;
    du_state_e next_state;
    logic      reg_addr_byte;
    logic      mem_addr_byte;

    assign reg_addr_byte = i_rx_valid && (state == ST_REG_ADDR);
    assign mem_addr_byte = i_rx_valid && (state == ST_MEM_ADDR);

    always_ff @(posedge i_du_clk) begin
        if (i_du_reset) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (i_rx_valid) begin
                    case (i_rx_data)
                        CMD_LOAD:     next_state = ST_LOAD;
                        CMD_RUN:      next_state = ST_RUN;
                        CMD_READ_REG: next_state = ST_REG_ADDR;
                        CMD_READ_MEM: next_state = ST_MEM_ADDR;
                        CMD_STEP:     next_state = ST_STEP;
                        CMD_RESET:    next_state = ST_RESET;
                        default:      next_state = ST_IDLE; // Unknown byte ignored
                    endcase
                end
            end
            ST_LOAD: begin
                if (i_load_done) begin
                    next_state = ST_IDLE;
                end
            end
            ST_REG_ADDR, ST_MEM_ADDR: begin
                if (i_rx_valid) begin
                    next_state = ST_SEND;
                end
            end
            ST_RUN: begin
                if (i_halt) begin
                    next_state = ST_IDLE; // CPU reached halt
                end
            end
            ST_STEP, ST_RESET: begin
                next_state = ST_IDLE; // Single cycle actions
            end
            ST_SEND: begin
                if (i_send_done) begin
                    next_state = ST_IDLE;
                end
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    // Read addresses and sender strobes
    always_ff @(posedge i_du_clk) begin
        if (i_du_reset) begin
            o_reg_addr <= '0;
            o_mem_addr <= '0;
            o_send_reg <= 1'b0;
            o_send_mem <= 1'b0;
        end else begin
            o_send_reg <= reg_addr_byte;
            o_send_mem <= mem_addr_byte;
            if (reg_addr_byte) begin
                o_reg_addr <= i_rx_data[`DU_REG_ADDR_W-1:0];
            end
            if (mem_addr_byte) begin
                o_mem_addr <= i_rx_data[`DU_MEM_ADDR_W-1:0];
            end
        end
    end

    // Loader clears its address on the command byte itself
    assign o_load_start      = i_rx_valid && (state == ST_IDLE) && (i_rx_data == CMD_LOAD);
    assign o_load_byte_valid = i_rx_valid && (state == ST_LOAD) && !i_load_done;

    assign o_clk_en    = (state == ST_RUN) || (state == ST_STEP);
    assign o_step_mode = (state == ST_STEP);
    assign o_cpu_reset = (state == ST_RESET);

endmodule

// File: source/du_cmd_pkg.sv
`include "du_macros.svh"

package du_cmd_pkg;

    // Host command bytes
    typedef enum logic [`DU_BYTE_W-1:0] {
        CMD_LOAD     = 8'h02,
        CMD_RUN      = 8'h05,
        CMD_READ_REG = 8'h06,
        CMD_READ_MEM = 8'h07,
        CMD_STEP     = 8'h0D,
        CMD_RESET    = 8'h0F
    } du_cmd_e;

    // Command decoder FSM
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_REG_ADDR,
        ST_MEM_ADDR,
        ST_RUN,
        ST_STEP,
        ST_RESET,
        ST_SEND
    } du_state_e;

endpackage

// File: source/du_cpu_pkg.sv
`include "du_macros.svh"

package du_cpu_pkg;

    typedef logic [`DU_BYTE_W-1:0]     du_byte_t;     // One host byte
    typedef logic [`DU_WORD_W-1:0]     du_word_t;     // Instruction or data word
    typedef logic [`DU_REG_ADDR_W-1:0] du_reg_addr_t; // Register file index
    typedef logic [`DU_MEM_ADDR_W-1:0] du_mem_addr_t; // Byte address into memories

endpackage

// File: source/du_macros.svh
`ifndef DU_MACROS_SVH
`define DU_MACROS_SVH

// Datapath widths fixed by the CPU
`define DU_BYTE_W         8
`define DU_WORD_W         32
`define DU_REG_ADDR_W     5
`define DU_MEM_ADDR_W     8

// Serial framing of one word
`define DU_BYTES_PER_WORD 4

// Byte advance per instruction
`define DU_ADDR_STEP      4

// End of program marker
`define DU_HALT_WORD      32'hFC00_0000

`endif

// File: source/du_program_loader.sv
`include "du_macros.svh"

module du_program_loader
    import du_cpu_pkg::*;
(
    input  logic         i_du_clk,
    input  logic         i_du_reset,
    input  logic         i_start,
    input  logic         i_byte_valid,
    input  du_byte_t     i_byte,
    output du_word_t     o_inst_data,
    output du_mem_addr_t o_inst_addr,
    output logic         o_inst_write_en,
    output logic         o_done
);

    localparam int CNT_W = $clog2(`DU_BYTES_PER_WORD);

    logic [CNT_W-1:0] byte_cnt;
    du_word_t         word_reg;
    du_word_t         word_next;
    logic             last_byte;

    assign word_next = {word_reg[`DU_WORD_W-`DU_BYTE_W-1:0], i_byte}; // First byte ends up MSB
    assign last_byte = i_byte_valid && (byte_cnt == CNT_W'(`DU_BYTES_PER_WORD - 1));

    always_ff @(posedge i_du_clk) begin
        if (i_byte_valid) begin
            word_reg <= word_next;
        end
    end

    always_ff @(posedge i_du_clk) begin
        if (i_du_reset) begin
            byte_cnt        <= '0;
            o_inst_write_en <= 1'b0;
            o_done          <= 1'b0;
        end else begin
            o_inst_write_en <= last_byte;
            o_done          <= last_byte && (word_next == `DU_HALT_WORD);
            if (i_start) begin
                byte_cnt <= '0;
            end else if (i_byte_valid) begin
                byte_cnt <= byte_cnt + 1'b1; // Wraps after the last byte
            end
        end
    end

    // Address moves on once the write cycle is over
    always_ff @(posedge i_du_clk) begin
        if (i_du_reset) begin
            o_inst_addr <= '0;
        end else if (i_start) begin
            o_inst_addr <= '0;
        end else if (o_inst_write_en) begin
            o_inst_addr <= o_inst_addr + `DU_MEM_ADDR_W'(`DU_ADDR_STEP);
        end
    end

    assign o_inst_data = word_reg;

endmodule

// File: source/du_word_sender.sv
`include "du_macros.svh"

module du_word_sender
    import du_cpu_pkg::*;
(
    input  logic     i_du_clk,
    input  logic     i_du_reset,
    input  logic     i_send_reg,
    input  logic     i_send_mem,
    input  du_word_t i_reg_word,
    input  du_word_t i_mem_word,
    output logic     o_tx_valid,
    output du_byte_t o_tx_data,
    output logic     o_done
);

    localparam int CNT_W = $clog2(`DU_BYTES_PER_WORD);

    logic [CNT_W-1:0] byte_cnt;
    du_word_t         shift_reg;
    logic             capture;

    assign capture = i_send_reg || i_send_mem;

    // Payload shifter sends the MSB first
    always_ff @(posedge i_du_clk) begin
        if (capture) begin
            shift_reg <= i_send_reg ? i_reg_word : i_mem_word;
        end else if (o_tx_valid) begin
            shift_reg <= {shift_reg[`DU_WORD_W-`DU_BYTE_W-1:0], {`DU_BYTE_W{1'b0}}};
        end
    end

    always_ff @(posedge i_du_clk) begin
        if (i_du_reset) begin
            o_tx_valid <= 1'b0;
            byte_cnt   <= '0;
        end else if (capture) begin
            o_tx_valid <= 1'b1;
            byte_cnt   <= '0;
        end else if (o_tx_valid) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (o_done) begin
                o_tx_valid <= 1'b0; // Fourth byte just went out
            end
        end
    end

    assign o_tx_data = shift_reg[`DU_WORD_W-1 -: `DU_BYTE_W];
    assign o_done    = o_tx_valid && (byte_cnt == CNT_W'(`DU_BYTES_PER_WORD - 1));

endmodule
